// File: all.f
+incdir+common
common/regFilePkg.sv
regFile/writeDecoder.sv
regFile/registerWord.sv
regFile/readPortMux.sv
regFile/registerFile.sv
verilog/aluUnit.sv
verilog/datapathTop.sv
tb/datapathChecker.sv
tb/datapathTb.sv

// File: common/regFilePkg.sv
`default_nettype none

`include "regFile_settings.svh"

package regFilePkg;

	////////////////////////////////////////////////////////////
	// width types
	////////////////////////////////////////////////////////////

	typedef logic [`REG_ADDR_WIDTH-1:0] regAddr_t;
	typedef logic [`DATA_WIDTH-1:0] dataWord_t;
	typedef logic [`REG_COUNT-1:0] wordEnable_t;
	typedef logic [15:0] immediate_t;

	// ALU operation codes
	typedef enum logic [3:0]
	{
		opAdd     = 4'd0,
		opSub     = 4'd1,
		opAnd     = 4'd2,
		opOr      = 4'd3,
		opXor     = 4'd4,
		// signed compare, result is 1 or 0
		opSlt     = 4'd5,
		opSll     = 4'd6,
		opSrl     = 4'd7,
		// zero-extended immediate
		opLoadImm = 4'd8
	} aluOp_t;

	// one issued instruction, 35 bits
	typedef struct packed
	{
		aluOp_t     op;
		regAddr_t   rd;
		regAddr_t   rs1;
		regAddr_t   rs2;
		immediate_t imm;
	} instruction_t;

endpackage

`default_nettype wire

// File: common/regFile_settings.svh
`ifndef REGFILE_SETTINGS_SVH
`define REGFILE_SETTINGS_SVH

////////////////////////////////////////////////////////////
// register file geometry
////////////////////////////////////////////////////////////

// number of architectural registers
`define REG_COUNT 32
// bits needed to name one register
`define REG_ADDR_WIDTH 5
// width of a register word and of the ALU datapath
`define DATA_WIDTH 32

`endif

// File: regFile/readPortMux.sv
`timescale 1ns/1ps
`default_nettype none

`include "regFile_settings.svh"

module readPortMux
	import regFilePkg::*;
(
	input  dataWord_t words [`REG_COUNT],
	input  regAddr_t  readAddr,
	output dataWord_t readData
);

	// four-way select used at every level of the tree
	function automatic dataWord_t pickFour
	(
		input dataWord_t in0,
		input dataWord_t in1,
		input dataWord_t in2,
		input dataWord_t in3,
		input logic [1:0] sel
	);
		dataWord_t picked;
		case (sel)
			2'd0: picked = in0;
			2'd1: picked = in1;
			2'd2: picked = in2;
			default: picked = in3;
		endcase
		return picked;
	endfunction

	dataWord_t firstStage [`REG_COUNT/4];
	dataWord_t secondStage [`REG_COUNT/16];

	////////////////////////////////////////////////////////////
	// stage one, address bits 1:0
	////////////////////////////////////////////////////////////

	for (genvar g = 0; g < `REG_COUNT/4; g++)
	begin : g_firstStage
		assign firstStage[g] = pickFour(words[4*g], words[4*g+1], words[4*g+2],
			words[4*g+3], readAddr[1:0]);
	end

	////////////////////////////////////////////////////////////
	// stage two, address bits 3:2
	////////////////////////////////////////////////////////////

	for (genvar g = 0; g < `REG_COUNT/16; g++)
	begin : g_secondStage
		assign secondStage[g] = pickFour(firstStage[4*g], firstStage[4*g+1],
			firstStage[4*g+2], firstStage[4*g+3], readAddr[3:2]);
	end

	// last level is a two-way pick on the top address bit
	assign readData = readAddr[4] ? secondStage[1] : secondStage[0];

endmodule

`default_nettype wire

// File: regFile/registerFile.sv
`timescale 1ns/1ps
`default_nettype none

`include "regFile_settings.svh"

module registerFile
	import regFilePkg::*;
(
	input  logic      clock,
	input  logic      rstN,
	input  regAddr_t  readAddrA,
	input  regAddr_t  readAddrB,
	input  regAddr_t  writeAddr,
	input  logic      writeEnable,
	input  dataWord_t writeData,
	output dataWord_t readDataA,
	output dataWord_t readDataB
);

	wordEnable_t wordEnable;
	dataWord_t   wordValue [`REG_COUNT];

	////////////////////////////////////////////////////////////
	// write side
	////////////////////////////////////////////////////////////

	writeDecoder i_writeDecoder
	(
		.writeAddr   (writeAddr),
		.writeEnable (writeEnable),
		.wordEnable  (wordEnable)
	);

	// every word sees the same write data, only its own enable
	for (genvar w = 0; w < `REG_COUNT; w++)
	begin : g_word
		registerWord i_registerWord
		(
			.clock     (clock),
			.rstN      (rstN),
			.load      (wordEnable[w]),
			.writeData (writeData),
			.value     (wordValue[w])
		);
	end

	////////////////////////////////////////////////////////////
	// read side
	////////////////////////////////////////////////////////////

	readPortMux i_readPortA
	(
		.words    (wordValue),
		.readAddr (readAddrA),
		.readData (readDataA)
	);

	readPortMux i_readPortB
	(
		.words    (wordValue),
		.readAddr (readAddrB),
		.readData (readDataB)
	);

endmodule

`default_nettype wire

// File: regFile/registerWord.sv
`timescale 1ns/1ps
`default_nettype none

module registerWord
	import regFilePkg::*;
(
	input  logic      clock,
	input  logic      rstN,
	input  logic      load,
	input  dataWord_t writeData,
	output dataWord_t value
);

	////////////////////////////////////////////////////////////
	// storage
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstN)
	begin
		if (!rstN)
		begin
			value <= '0;
		end
		else if (load)
		begin
			// holds its value whenever load is low
			value <= writeData;
		end
	end

endmodule

`default_nettype wire

// File: regFile/writeDecoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "regFile_settings.svh"

module writeDecoder
	import regFilePkg::*;
(
	input  regAddr_t    writeAddr,
	input  logic        writeEnable,
	output wordEnable_t wordEnable
);

	// one-hot decode of the write address, gated by the write enable
	always_comb
	begin
		wordEnable = '0;
		for (int i = 0; i < `REG_COUNT; i++)
		begin
			if (writeEnable && (writeAddr == regAddr_t'(i)))
			begin
				wordEnable[i] = 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: tb/datapathChecker.sv
`timescale 1ns/1ps
`default_nettype none

module datapathChecker
	import regFilePkg::*;
(
	input logic      clock,
	input logic      rstN,
	input logic      issue,
	input logic      resultValid,
	input dataWord_t result
);

	// read by the testbench when it closes the run
	int assertFailures = 0;

	////////////////////////////////////////////////////////////
	// result timing
	////////////////////////////////////////////////////////////

	validFollowsIssue: assert property (@(posedge clock) disable iff (!rstN)
		resultValid == $past(issue))
	else
	begin
		assertFailures++;
		$error("resultValid is not issue delayed by one cycle");
	end

	validLowInReset: assert property (@(posedge clock) !rstN |-> !resultValid)
	else
	begin
		assertFailures++;
		$error("resultValid is high while reset is asserted");
	end

	// result only moves on the edge that raises resultValid
	resultHeld: assert property (@(posedge clock) disable iff (!rstN)
		!resultValid |-> $stable(result))
	else
	begin
		assertFailures++;
		$error("result changed without a valid pulse");
	end

endmodule

bind datapathTop datapathChecker i_datapathChecker
(
	.clock       (clock),
	.rstN        (rstN),
	.issue       (issue),
	.resultValid (resultValid),
	.result      (result)
);

`default_nettype wire

// File: tb/datapathTb.sv
`timescale 1ns/1ps
`default_nettype none

`include "regFile_settings.svh"

module datapathTb
	import regFilePkg::*;
();

	localparam int clockPeriod = 40;
	// 32 + 64 + 49 + 10 + 33 + 32 issues over the six tests
	localparam int totalIssues = 220;

	logic         clock;
	logic         rstN;
	instruction_t instruction;
	logic         issue;
	dataWord_t    result;
	logic         resultValid;

	dataWord_t model [`REG_COUNT];
	int        errorCount = 0;
	int        checkCount = 0;
	integer    seed = 32'h064d_4b63;

	datapathTop i_datapathTop
	(
		.clock       (clock),
		.rstN        (rstN),
		.instruction (instruction),
		.issue       (issue),
		.result      (result),
		.resultValid (resultValid)
	);

	initial
	begin
		clock = 1'b0;
		forever
		begin
			#(clockPeriod/2) clock = ~clock;
		end
	end

	initial
	begin
		#((totalIssues + 50) * clockPeriod);
		$display("timeout: the tests did not finish in time");
		$display("TEST RESULT: FAIL");
		$finish;
	end

	////////////////////////////////////////////////////////////
	// reference model and checking
	////////////////////////////////////////////////////////////

	function automatic dataWord_t modelAlu(input aluOp_t op, input dataWord_t a,
		input dataWord_t b, input immediate_t imm);
		dataWord_t value;
		case (op)
			opAdd:     value = a + b;
			opSub:     value = a - b;
			opAnd:     value = a & b;
			opOr:      value = a | b;
			opXor:     value = a ^ b;
			opSlt:     value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			opSll:     value = a << b[4:0];
			opSrl:     value = a >> b[4:0];
			opLoadImm: value = {16'h0000, imm};
			default:   value = '0;
		endcase
		return value;
	endfunction

	task automatic checkValue(input dataWord_t actual, input dataWord_t expected,
		input string what);
		checkCount++;
		if (actual !== expected)
		begin
			errorCount++;
			$display("[FAIL] %0d ns %s: got %h, expected %h", $time, what, actual, expected);
		end
	endtask

	// drives one issue and checks it after the next edge with issue left low
	task automatic issueOp(input aluOp_t op, input regAddr_t rd, input regAddr_t rs1,
		input regAddr_t rs2, input immediate_t imm);
		dataWord_t expected;
		expected = modelAlu(op, model[rs1], model[rs2], imm);
		instruction.op  = op;
		instruction.rd  = rd;
		instruction.rs1 = rs1;
		instruction.rs2 = rs2;
		instruction.imm = imm;
		issue = 1'b1;
		@(posedge clock);
		#2;
		issue = 1'b0;
		model[rd] = expected;
		checkValue(dataWord_t'(resultValid), 32'd1, "resultValid after issue");
		checkValue(result, expected, $sformatf("%s rd=%0d rs1=%0d rs2=%0d", op.name(),
			rd, rs1, rs2));
	endtask

	// or of a register with itself writes back the same value
	task automatic readAll();
		for (int i = 0; i < `REG_COUNT; i++)
		begin
			issueOp(opOr, regAddr_t'(i), regAddr_t'(i), regAddr_t'(i), 16'h0000);
		end
	endtask

	////////////////////////////////////////////////////////////
	// directed tests
	////////////////////////////////////////////////////////////

	task automatic resetValuesTest();
		for (int i = 0; i < `REG_COUNT; i++)
		begin
			issueOp(opAdd, regAddr_t'(i), regAddr_t'(i), regAddr_t'(i), 16'h0000);
		end
	endtask

	task automatic loadAllTest();
		for (int i = 0; i < `REG_COUNT; i++)
		begin
			issueOp(opLoadImm, regAddr_t'(i), 5'd0, 5'd0, immediate_t'(16'h0a05 + i * 16'h0101));
		end
		readAll();
	endtask

	// 32-bit words are built from two immediates
	// r20 holds the shift of 16
	task automatic randomOpsTest();
		dataWord_t word;
		regAddr_t  pairA [4];
		regAddr_t  pairB [4];
		pairA = '{5'd1, 5'd2, 5'd3, 5'd1};
		pairB = '{5'd2, 5'd1, 5'd4, 5'd3};
		issueOp(opLoadImm, 5'd20, 5'd0, 5'd0, 16'd16);
		for (int r = 1; r <= 4; r++)
		begin
			word = $random(seed);
			if (r == 1)
				word[31] = 1'b1;
			if (r == 3)
				word[31] = 1'b0;
			issueOp(opLoadImm, regAddr_t'(r), 5'd0, 5'd0, word[31:16]);
			issueOp(opSll, regAddr_t'(r), regAddr_t'(r), 5'd20, 16'h0000);
			issueOp(opLoadImm, 5'd21, 5'd0, 5'd0, word[15:0]);
			issueOp(opOr, regAddr_t'(r), regAddr_t'(r), 5'd21, 16'h0000);
		end
		for (int p = 0; p < 4; p++)
		begin
			for (int k = 0; k < 8; k++)
			begin
				issueOp(aluOp_t'(k), 5'd22, pairA[p], pairB[p], 16'h0000);
			end
		end
	endtask

	task automatic backToBackTest();
		for (int k = 0; k < 10; k++)
		begin
			issueOp(opAdd, 5'd7, 5'd7, 5'd3, 16'h0000);
		end
	endtask

	task automatic singleWriteTest();
		issueOp(opLoadImm, 5'd9, 5'd0, 5'd0, 16'hbeef);
		readAll();
	endtask

	// an instruction that would change r5 waits without issue
	task automatic idleTest();
		instruction.op  = opLoadImm;
		instruction.rd  = 5'd5;
		instruction.rs1 = 5'd0;
		instruction.rs2 = 5'd0;
		instruction.imm = 16'h5a5a;
		repeat (6)
		begin
			@(posedge clock);
			#2;
			checkValue(dataWord_t'(resultValid), 32'd0, "resultValid while idle");
		end
		readAll();
	endtask

	initial
	begin
		rstN = 1'b1;
		issue = 1'b0;
		instruction = '0;
		for (int i = 0; i < `REG_COUNT; i++)
		begin
			model[i] = '0;
		end
		#2;
		rstN = 1'b0;
		repeat (8) @(posedge clock);
		#2;
		rstN = 1'b1;
		resetValuesTest();
		loadAllTest();
		randomOpsTest();
		backToBackTest();
		singleWriteTest();
		idleTest();
		$display("checks %0d, errors %0d, assertion failures %0d", checkCount, errorCount,
			i_datapathTop.i_datapathChecker.assertFailures);
		if (errorCount == 0 && i_datapathTop.i_datapathChecker.assertFailures == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: verilog/aluUnit.sv
`timescale 1ns/1ps
`default_nettype none

module aluUnit
	import regFilePkg::*;
(
	input  aluOp_t     op,
	input  dataWord_t  operandA,
	input  dataWord_t  operandB,
	input  immediate_t imm,
	output dataWord_t  aluResult
);

	logic [4:0] shiftAmount;
	logic       lessThan;
	dataWord_t  sum;
	dataWord_t  difference;
	dataWord_t  immExtended;

	// only the low five bits of b count for shifts
	assign shiftAmount = operandB[4:0];

	// add and sub wrap, carry out is dropped
	assign sum        = operandA + operandB;
	assign difference = operandA - operandB;

	assign lessThan = $signed(operandA) < $signed(operandB);

	assign immExtended = dataWord_t'(imm);

	////////////////////////////////////////////////////////////
	// result select
	////////////////////////////////////////////////////////////

	always_comb
	begin
		case (op)
			opAdd:     aluResult = sum;
			opSub:     aluResult = difference;
			opAnd:     aluResult = operandA & operandB;
			opOr:      aluResult = operandA | operandB;
			opXor:     aluResult = operandA ^ operandB;
			opSlt:     aluResult = dataWord_t'(lessThan);
			opSll:     aluResult = operandA << shiftAmount;
			opSrl:     aluResult = operandA >> shiftAmount;
			opLoadImm: aluResult = immExtended;
			// unused codes give zero
			default:   aluResult = '0;
		endcase
	end

endmodule

`default_nettype wire

// File: verilog/datapathTop.sv
`timescale 1ns/1ps
`default_nettype none

module datapathTop
	import regFilePkg::*;
(
	input  logic         clock,
	input  logic         rstN,
	input  instruction_t instruction,
	input  logic         issue,
	output dataWord_t    result,
	output logic         resultValid
);

	dataWord_t readDataA;
	dataWord_t readDataB;
	dataWord_t aluResult;

	////////////////////////////////////////////////////////////
	// register read and write-back
	////////////////////////////////////////////////////////////

	// write-back lands on the issuing edge, so the next issue already sees it
	registerFile i_registerFile
	(
		.clock       (clock),
		.rstN        (rstN),
		.readAddrA   (instruction.rs1),
		.readAddrB   (instruction.rs2),
		.writeAddr   (instruction.rd),
		.writeEnable (issue),
		.writeData   (aluResult),
		.readDataA   (readDataA),
		.readDataB   (readDataB)
	);

	////////////////////////////////////////////////////////////
	// execute
	////////////////////////////////////////////////////////////

	aluUnit i_aluUnit
	(
		.op        (instruction.op),
		.operandA  (readDataA),
		.operandB  (readDataB),
		.imm       (instruction.imm),
		.aluResult (aluResult)
	);

	// result copy for the outside, valid for one cycle per issue
	always_ff @(posedge clock or negedge rstN)
	begin
		if (!rstN)
		begin
			result      <= '0;
			resultValid <= 1'b0;
		end
		else
		begin
			resultValid <= issue;
			if (issue)
			begin
				result <= aluResult;
			end
		end
	end

endmodule

`default_nettype wire
